// File: common/axi_ll_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI write logic link shared definitions
// Field widths, packed channel words, PHY bit positions and link
// defaults for the write-side master
//////////////////////////////////////////////////////////////////////

`default_nettype none

package axi_ll_pkg;

  // AXI field widths
  localparam int ID_W    = 4;
  localparam int ADDR_W  = 32;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;
  localparam int RESP_W  = 2;

  // Packed channel words, fields listed msb first
  // AW is id, size, len, burst, addr
  localparam int AW_WORD_W = ID_W + SIZE_W + LEN_W + BURST_W + ADDR_W;
  // W is id, data, strb, last
  localparam int W_WORD_W  = ID_W + DATA_W + STRB_W + 1;
  // B is id, resp
  localparam int B_WORD_W  = ID_W + RESP_W;

  // Transmit PHY word, bit 0 upward
  localparam int TX_AW_PUSH_BIT = 0;
  localparam int TX_W_PUSH_BIT  = 1;
  localparam int TX_B_CRED_BIT  = 2;
  localparam int TX_AW_WORD_LSB = 3;
  localparam int TX_W_WORD_LSB  = TX_AW_WORD_LSB + AW_WORD_W;
  localparam int TX_PHY_W       = TX_W_WORD_LSB + W_WORD_W;

  // Receive PHY word, bit 0 upward
  localparam int RX_AW_CRED_BIT = 0;
  localparam int RX_W_CRED_BIT  = 1;
  localparam int RX_B_PUSH_BIT  = 2;
  localparam int RX_B_WORD_LSB  = 3;
  localparam int RX_PHY_W       = RX_B_WORD_LSB + B_WORD_W;

  // Link defaults
  localparam int CRED_W       = 8;
  localparam int B_FIFO_DEPTH = 8;
  localparam int DELAY_W      = 16;

endpackage

`default_nettype wire

// File: hdl/ll_auto_sync.sv
//////////////////////////////////////////////////////////////////////
// Link online qualifier
// Holds off the rise of each online flag by a programmed cycle count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ll_auto_sync
  import axi_ll_pkg::*;
(
  input  logic               clk_wr,
  input  logic               rst_n,
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  output logic               tx_online_delay,
  output logic               rx_online_delay
);

  // Index 0 is the tx side, index 1 the rx side
  logic [1:0]         online;
  logic [1:0]         online_q;
  logic [DELAY_W-1:0] delay_val [2];
  logic [DELAY_W-1:0] cnt       [2];

  assign online       = {rx_online, tx_online};
  assign delay_val[0] = delay_x_value;
  assign delay_val[1] = delay_y_value;

  // Reload while down, count while up, flag at zero
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        cnt[i] <= '0;
      end
      online_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online[i]) begin
          cnt[i]      <= delay_val[i];
          online_q[i] <= 1'b0;
        end else begin
          if (cnt[i] != '0) begin
            cnt[i] <= cnt[i] - 1'b1;
          end
          online_q[i] <= (cnt[i] == '0);
        end
      end
    end
  end

  assign tx_online_delay = online_q[0];
  assign rx_online_delay = online_q[1];

endmodule

`default_nettype wire

// File: ll_transmit/ll_transmit.sv
//////////////////////////////////////////////////////////////////////
// Logic link transmit stage
// Credit gated one entry stage for a single channel, sends each
// accepted item as a one cycle pushbit on the next cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ll_transmit
  import axi_ll_pkg::*;
#(
  parameter int WIDTH = AW_WORD_W
) (
  input  logic              clk_wr,
  input  logic              rst_n,
  input  logic              tx_online,
  input  logic              rx_online,
  input  logic [CRED_W-1:0] init_credit,
  input  logic              user_valid,
  input  logic [WIDTH-1:0]  user_data,
  input  logic              rx_credit,
  output logic              user_ready,
  output logic [WIDTH-1:0]  tx_data,
  output logic              tx_pushbit
);

  logic              online;
  logic              online_q;
  logic              accept;
  logic [CRED_W-1:0] cred_cnt;
  logic [WIDTH-1:0]  stage_data;

  assign online = tx_online & rx_online;

  // Stage drains every cycle, so only credit and link state gate ready
  assign user_ready = online & (cred_cnt != '0);
  assign accept     = user_valid & user_ready;

  //////////////////////////////////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      online_q <= 1'b0;
      cred_cnt <= '0;
    end else begin
      online_q <= online;
      if (!online) begin
        cred_cnt <= '0;
      end else if (!online_q) begin
        // Link just came up
        cred_cnt <= init_credit;
      end else begin
        case ({rx_credit, accept})
          2'b10:   cred_cnt <= cred_cnt + 1'b1;
          2'b01:   cred_cnt <= cred_cnt - 1'b1;
          default: cred_cnt <= cred_cnt;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Staging register

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_pushbit <= 1'b0;
    end else begin
      tx_pushbit <= accept;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (accept) begin
      stage_data <= user_data;
    end
  end

  assign tx_data = stage_data;

endmodule

`default_nettype wire

// File: ll_receive/ll_receive.sv
//////////////////////////////////////////////////////////////////////
// Logic link receive FIFO
// First word fall through buffer for one channel, returns a credit
// pulse to the far side for every entry popped
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module ll_receive
  import axi_ll_pkg::*;
#(
  parameter int WIDTH = B_WORD_W,
  parameter int DEPTH = B_FIFO_DEPTH
) (
  input  logic             clk_wr,
  input  logic             rst_n,
  input  logic             rx_online,
  input  logic [WIDTH-1:0] rx_data,
  input  logic             rx_pushbit,
  input  logic             user_ready,
  output logic             user_valid,
  output logic [WIDTH-1:0] user_data,
  output logic             tx_credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  assign full = (count == CNT_W'(DEPTH));

  // Far side never pushes without credit, full only guards the array
  assign push = rx_online & rx_pushbit & ~full;

  // Head entry shown directly
  assign user_valid = rx_online & (count != '0);
  assign user_data  = mem[rd_ptr];
  assign pop        = user_valid & user_ready;

  //////////////////////////////////////////////////////////////////////
  // Pointers, count and credit return

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      tx_credit <= 1'b0;
    end else begin
      tx_credit <= pop;
      if (!rx_online) begin
        // Flush while the link is down
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr] <= rx_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/axi_wr_ll_master.sv
//////////////////////////////////////////////////////////////////////
// AXI write master over a credit based logic link
// Tunnels AW and W to the far side and brings B back through a FIFO,
// all carried in one tx PHY word and one rx PHY word
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module axi_wr_ll_master
  import axi_ll_pkg::*;
(
  input  logic                clk_wr,
  input  logic                rst_n,

  // Link control
  input  logic                tx_online,
  input  logic                rx_online,
  input  logic [CRED_W-1:0]   init_aw_credit,
  input  logic [CRED_W-1:0]   init_w_credit,
  input  logic [DELAY_W-1:0]  delay_x_value,
  input  logic [DELAY_W-1:0]  delay_y_value,

  // PHY words
  output logic [TX_PHY_W-1:0] tx_phy,
  input  logic [RX_PHY_W-1:0] rx_phy,

  // AW channel
  input  logic [ID_W-1:0]     awid,
  input  logic [SIZE_W-1:0]   awsize,
  input  logic [LEN_W-1:0]    awlen,
  input  logic [BURST_W-1:0]  awburst,
  input  logic [ADDR_W-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,

  // W channel
  input  logic [ID_W-1:0]     wid,
  input  logic [DATA_W-1:0]   wdata,
  input  logic [STRB_W-1:0]   wstrb,
  input  logic                wlast,
  input  logic                wvalid,
  output logic                wready,

  // B channel
  output logic [ID_W-1:0]     bid,
  output logic [RESP_W-1:0]   bresp,
  output logic                bvalid,
  input  logic                bready
);

  logic                  tx_online_delay;
  logic                  rx_online_delay;

  logic [AW_WORD_W-1:0]  aw_word;
  logic [AW_WORD_W-1:0]  aw_tx_data;
  logic                  aw_pushbit;
  logic                  aw_credit;

  logic [W_WORD_W-1:0]   w_word;
  logic [W_WORD_W-1:0]   w_tx_data;
  logic                  w_pushbit;
  logic                  w_credit;

  logic [B_WORD_W-1:0]   b_rx_data;
  logic [B_WORD_W-1:0]   b_word;
  logic                  b_pushbit;
  logic                  b_credit;

  //////////////////////////////////////////////////////////////////////
  // Link bring-up

  ll_auto_sync sync0 (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  //////////////////////////////////////////////////////////////////////
  // Channel packing

  assign aw_word = {awid, awsize, awlen, awburst, awaddr};
  assign w_word  = {wid, wdata, wstrb, wlast};
  assign {bid, bresp} = b_word;

  //////////////////////////////////////////////////////////////////////
  // Logic link channels

  ll_transmit #(.WIDTH(AW_WORD_W)) aw_tx0 (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online_delay),
    .rx_online   (rx_online_delay),
    .init_credit (init_aw_credit),
    .user_valid  (awvalid),
    .user_data   (aw_word),
    .rx_credit   (aw_credit),
    .user_ready  (awready),
    .tx_data     (aw_tx_data),
    .tx_pushbit  (aw_pushbit)
  );

  ll_transmit #(.WIDTH(W_WORD_W)) w_tx0 (
    .clk_wr      (clk_wr),
    .rst_n       (rst_n),
    .tx_online   (tx_online_delay),
    .rx_online   (rx_online_delay),
    .init_credit (init_w_credit),
    .user_valid  (wvalid),
    .user_data   (w_word),
    .rx_credit   (w_credit),
    .user_ready  (wready),
    .tx_data     (w_tx_data),
    .tx_pushbit  (w_pushbit)
  );

  // Far side gets B_FIFO_DEPTH credits implicitly once online
  ll_receive #(.WIDTH(B_WORD_W), .DEPTH(B_FIFO_DEPTH)) b_rx0 (
    .clk_wr     (clk_wr),
    .rst_n      (rst_n),
    .rx_online  (rx_online_delay),
    .rx_data    (b_rx_data),
    .rx_pushbit (b_pushbit),
    .user_ready (bready),
    .user_valid (bvalid),
    .user_data  (b_word),
    .tx_credit  (b_credit)
  );

  //////////////////////////////////////////////////////////////////////
  // PHY words

  assign aw_credit = rx_phy[RX_AW_CRED_BIT];
  assign w_credit  = rx_phy[RX_W_CRED_BIT];
  assign b_pushbit = rx_phy[RX_B_PUSH_BIT];
  assign b_rx_data = rx_phy[RX_B_WORD_LSB +: B_WORD_W];

  // W word on top, then AW word, then the three control bits
  assign tx_phy = {w_tx_data, aw_tx_data, b_credit, w_pushbit, aw_pushbit};

endmodule

`default_nettype wire

// File: verif/axi_wr_ll_checker.sv
//////////////////////////////////////////////////////////////////////
// Protocol checker for the AXI write logic link master
// Concurrent assertions on pushbit timing, B credit return, B hold
// and ready gating, bound into the top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module axi_wr_ll_checker
  import axi_ll_pkg::*;
(
  input logic                clk_wr,
  input logic                rst_n,
  input logic                tx_online,
  input logic                rx_online,
  input logic                rx_online_delay,
  input logic                awvalid,
  input logic                awready,
  input logic                wvalid,
  input logic                wready,
  input logic                bvalid,
  input logic                bready,
  input logic [ID_W-1:0]     bid,
  input logic [RESP_W-1:0]   bresp,
  input logic [TX_PHY_W-1:0] tx_phy
);

  int fail_count = 0;

  // Pushbit one cycle after acceptance and never otherwise
  aw_push_timing: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy[TX_AW_PUSH_BIT] == $past(awvalid && awready))
    else begin fail_count++; $error("aw pushbit not one cycle after AW acceptance"); end

  w_push_timing: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy[TX_W_PUSH_BIT] == $past(wvalid && wready))
    else begin fail_count++; $error("w pushbit not one cycle after W acceptance"); end

  b_credit_timing: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy[TX_B_CRED_BIT] == $past(bvalid && bready))
    else begin fail_count++; $error("b credit pulse not one cycle after B pop"); end

  // Flush while offline is allowed to drop bvalid
  b_hold: assert property (@(posedge clk_wr) disable iff (!rst_n || !rx_online_delay)
    (bvalid && !bready) |=> (bvalid && $stable(bid) && $stable(bresp)))
    else begin fail_count++; $error("bvalid or B fields changed while bready low"); end

  // Either raw online input low clears ready by the next edge
  ready_offline: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !(tx_online && rx_online) |=> (!awready && !wready))
    else begin fail_count++; $error("awready or wready high while link offline"); end

endmodule

bind axi_wr_ll_master axi_wr_ll_checker chk0 (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .tx_online       (tx_online),
  .rx_online       (rx_online),
  .rx_online_delay (rx_online_delay),
  .awvalid         (awvalid),
  .awready         (awready),
  .wvalid          (wvalid),
  .wready          (wready),
  .bvalid          (bvalid),
  .bready          (bready),
  .bid             (bid),
  .bresp           (bresp),
  .tx_phy          (tx_phy)
);

`default_nettype wire

// File: verif/tb_axi_wr_ll.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the AXI write logic link master
// Acts as the far-side link partner, drives AXI traffic and checks
// the tx PHY word and the B responses against queued expected values
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_axi_wr_ll
  import axi_ll_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int WATCHDOG_CYCLES = 2000;
  localparam int WAIT_LIMIT      = 100;
  localparam int DELAY_X         = 5;
  localparam int DELAY_Y         = 3;
  localparam int AW_CREDITS      = 3;
  localparam int W_CREDITS       = 3;

  logic                clk_wr;
  logic                rst_n;
  logic                tx_online;
  logic                rx_online;
  logic [CRED_W-1:0]   init_aw_credit;
  logic [CRED_W-1:0]   init_w_credit;
  logic [DELAY_W-1:0]  delay_x_value;
  logic [DELAY_W-1:0]  delay_y_value;
  logic [TX_PHY_W-1:0] tx_phy;
  logic [RX_PHY_W-1:0] rx_phy;
  logic [ID_W-1:0]     awid;
  logic [SIZE_W-1:0]   awsize;
  logic [LEN_W-1:0]    awlen;
  logic [BURST_W-1:0]  awburst;
  logic [ADDR_W-1:0]   awaddr;
  logic                awvalid;
  logic                awready;
  logic [ID_W-1:0]     wid;
  logic [DATA_W-1:0]   wdata;
  logic [STRB_W-1:0]   wstrb;
  logic                wlast;
  logic                wvalid;
  logic                wready;
  logic [ID_W-1:0]     bid;
  logic [RESP_W-1:0]   bresp;
  logic                bvalid;
  logic                bready;

  // Far-side drivers of the rx PHY word
  logic                aw_cred;
  logic                w_cred;
  logic                b_push;
  logic [B_WORD_W-1:0] b_word_drv;

  logic [15:0]          lfsr_state;
  logic [AW_WORD_W-1:0] aw_exp_q [$];
  logic [W_WORD_W-1:0]  w_exp_q [$];
  logic [B_WORD_W-1:0]  b_exp_q [$];
  int                   b_credits;
  logic                 b_cred_due;
  int                   n;

  assign rx_phy = {b_word_drv, b_push, w_cred, aw_cred};

  axi_wr_ll_master dut0 (
    .clk_wr (clk_wr), .rst_n (rst_n), .tx_online (tx_online), .rx_online (rx_online),
    .init_aw_credit (init_aw_credit), .init_w_credit (init_w_credit),
    .delay_x_value (delay_x_value), .delay_y_value (delay_y_value),
    .tx_phy (tx_phy), .rx_phy (rx_phy),
    .awid (awid), .awsize (awsize), .awlen (awlen), .awburst (awburst),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wid (wid), .wdata (wdata), .wstrb (wstrb), .wlast (wlast),
    .wvalid (wvalid), .wready (wready),
    .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int bits);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < bits; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    assert (act === exp) else
      stop_run($sformatf("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act));
  endtask

  task automatic wait_ready(input logic is_w, output int cycles);
    cycles = 0;
    @(negedge clk_wr);
    while (!(is_w ? wready : awready)) begin
      cycles++;
      assert (cycles < WAIT_LIMIT) else
        stop_run($sformatf("Timed out waiting for %s", is_w ? "wready" : "awready"));
      @(negedge clk_wr);
    end
  endtask

  task automatic pulse_credit(input logic is_w);
    @(posedge clk_wr);
    #1;
    aw_cred = ~is_w;
    w_cred  = is_w;
    @(posedge clk_wr);
    #1;
    aw_cred = 1'b0;
    w_cred  = 1'b0;
  endtask

  // Ready must stay low for hold cycles, then one credit releases it
  task automatic stall_cycles(input logic is_w, input int hold);
    repeat (hold) begin
      @(negedge clk_wr);
      assert (!(is_w ? wready : awready)) else
        stop_run($sformatf("%s high with no credit left", is_w ? "wready" : "awready"));
    end
    if (hold > 0) begin
      pulse_credit(is_w);
    end
  endtask

  task automatic aw_transfer(input int hold);
    int cycles;
    @(posedge clk_wr);
    #1;
    awid    = ID_W'(rand_bits(ID_W));
    awsize  = SIZE_W'(rand_bits(SIZE_W));
    awlen   = LEN_W'(rand_bits(LEN_W));
    awburst = BURST_W'(rand_bits(BURST_W));
    awaddr  = rand_bits(ADDR_W);
    awvalid = 1'b1;
    stall_cycles(1'b0, hold);
    wait_ready(1'b0, cycles);
    aw_exp_q.push_back({awid, awsize, awlen, awburst, awaddr});
    @(posedge clk_wr);
    #1;
    awvalid = 1'b0;
  endtask

  task automatic w_transfer(input int hold);
    int cycles;
    @(posedge clk_wr);
    #1;
    wid    = ID_W'(rand_bits(ID_W));
    wdata  = rand_bits(DATA_W);
    wstrb  = STRB_W'(rand_bits(STRB_W));
    wlast  = 1'(rand_bits(1));
    wvalid = 1'b1;
    stall_cycles(1'b1, hold);
    wait_ready(1'b1, cycles);
    w_exp_q.push_back({wid, wdata, wstrb, wlast});
    @(posedge clk_wr);
    #1;
    wvalid = 1'b0;
  endtask

  task automatic b_push_item();
    logic [B_WORD_W-1:0] word;
    word = B_WORD_W'(rand_bits(B_WORD_W));
    assert (b_credits > 0) else stop_run("Far side ran out of B credit");
    @(posedge clk_wr);
    #1;
    b_word_drv = word;
    b_push     = 1'b1;
    b_credits--;
    b_exp_q.push_back(word);
    @(posedge clk_wr);
    #1;
    b_push = 1'b0;
  endtask

  task automatic wait_b_drain();
    int cycles;
    cycles = 0;
    while (b_exp_q.size() != 0) begin
      cycles++;
      assert (cycles < WAIT_LIMIT) else stop_run("B responses never drained");
      @(negedge clk_wr);
    end
    repeat (2) @(negedge clk_wr);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Far-side monitor, sampled mid-cycle

  always @(negedge clk_wr) begin
    if (rst_n) begin
      if (tx_phy[TX_AW_PUSH_BIT]) begin
        assert (aw_exp_q.size() > 0) else stop_run("AW pushbit with no accepted transfer");
        check_value("tx_phy aw word", 64'(aw_exp_q.pop_front()),
                    64'(tx_phy[TX_AW_WORD_LSB +: AW_WORD_W]));
      end
      if (tx_phy[TX_W_PUSH_BIT]) begin
        assert (w_exp_q.size() > 0) else stop_run("W pushbit with no accepted transfer");
        check_value("tx_phy w word", 64'(w_exp_q.pop_front()),
                    64'(tx_phy[TX_W_WORD_LSB +: W_WORD_W]));
      end
      check_value("tx_phy b credit", 64'(b_cred_due), 64'(tx_phy[TX_B_CRED_BIT]));
      if (tx_phy[TX_B_CRED_BIT]) begin
        b_credits++;
      end
      // Pop happens on the coming edge
      b_cred_due = bvalid && bready;
      if (b_cred_due) begin
        assert (b_exp_q.size() > 0) else stop_run("bvalid with no B item pushed");
        check_value("bid,bresp", 64'(b_exp_q.pop_front()), 64'({bid, bresp}));
      end
      assert (dut0.chk0.fail_count == 0) else stop_run("A bound checker assertion failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_wr);
    stop_run($sformatf("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES));
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    lfsr_state     = 16'd82;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    init_aw_credit = CRED_W'(AW_CREDITS);
    init_w_credit  = CRED_W'(W_CREDITS);
    delay_x_value  = DELAY_W'(DELAY_X);
    delay_y_value  = DELAY_W'(DELAY_Y);
    {awid, awsize, awlen, awburst, awaddr, awvalid} = '0;
    {wid, wdata, wstrb, wlast, wvalid} = '0;
    bready     = 1'b0;
    aw_cred    = 1'b0;
    w_cred     = 1'b0;
    b_push     = 1'b0;
    b_word_drv = '0;
    b_credits  = B_FIFO_DEPTH;
    b_cred_due = 1'b0;
    repeat (8) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Bring-up
    @(negedge clk_wr);
    assert (!awready && !wready && !bvalid) else stop_run("Ready or bvalid high after reset");
    @(posedge clk_wr);
    #1;
    tx_online = 1'b1;
    rx_online = 1'b1;
    wait_ready(1'b0, n);
    assert (n >= DELAY_X) else
      stop_run($sformatf("awready rose %0d cycles after tx_online, before the delay", n));

    // AW with credit exhaustion and single credit release
    repeat (AW_CREDITS) aw_transfer(0);
    repeat (2) aw_transfer(10);
    repeat (3) pulse_credit(1'b0);
    repeat (3) aw_transfer(0);
    aw_transfer(6);

    // Same for W
    repeat (W_CREDITS) w_transfer(0);
    repeat (2) w_transfer(10);
    repeat (3) pulse_credit(1'b1);
    repeat (3) w_transfer(0);
    w_transfer(6);

    // B held off, then random bready
    repeat (3) b_push_item();
    repeat (6) begin
      @(negedge clk_wr);
      assert (bvalid) else stop_run("bvalid low while B items wait");
    end
    @(posedge clk_wr);
    #1;
    bready = 1'b1;
    wait_b_drain();
    repeat (5) begin
      b_push_item();
      bready = 1'(rand_bits(1));
    end
    bready = 1'b1;
    wait_b_drain();
    check_value("b credits returned", 64'(B_FIFO_DEPTH), 64'(b_credits));

    // Drop tx_online while both channels hold a credit
    pulse_credit(1'b0);
    pulse_credit(1'b1);
    @(negedge clk_wr);
    assert (awready && wready) else stop_run("Ready low with a credit in hand");
    @(posedge clk_wr);
    #1;
    tx_online = 1'b0;
    repeat (2) @(negedge clk_wr);
    assert (!awready && !wready) else stop_run("Ready still high a cycle after tx_online fell");
    @(posedge clk_wr);
    #1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    repeat (10) begin
      @(negedge clk_wr);
      assert (!awready && !wready) else stop_run("Ready high while offline");
    end

    if (aw_exp_q.size() == 0 && w_exp_q.size() == 0 && b_exp_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_run("Expected items were never delivered");
    end
  end

endmodule

`default_nettype wire

// File: axi_wr_ll_master.f
common/axi_ll_pkg.sv
hdl/ll_auto_sync.sv
ll_transmit/ll_transmit.sv
ll_receive/ll_receive.sv
hdl/axi_wr_ll_master.sv
verif/axi_wr_ll_checker.sv
verif/tb_axi_wr_ll.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI write logic link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axi_wr_ll \
  -f axi_wr_ll_master.f \
  -o sim_tb_axi_wr_ll

# Error limit lets the testbench see a bound assertion failure
output=$(./obj_dir/sim_tb_axi_wr_ll +verilator+error+limit+10 2>&1) || {
  echo "$output"
  exit 1
}
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
  exit 0
else
  exit 1
fi
